// File: src/flopRamFifo_settings.svh
`ifndef FLOP_RAM_FIFO_SETTINGS_SVH
`define FLOP_RAM_FIFO_SETTINGS_SVH

// ----------------------------------------
// FIFO geometry
// ----------------------------------------

// Number of RAM entries, power of two and at least 2
`define FLOP_RAM_FIFO_DEPTH 8

// Bits per stored word
`define FLOP_RAM_FIFO_WIDTH 16

// ----------------------------------------
// RAM pipeline depths
// ----------------------------------------

// Write pipeline depth, at least 1
`define FLOP_RAM_FIFO_WR_LATENCY 2
// Read pipeline depth, 0 means combinational read
`define FLOP_RAM_FIFO_RD_LATENCY 1

`endif

// File: src/flopRamFifoPkg.sv
`include "flopRamFifo_settings.svh"

package flopRamFifoPkg;

  // ----------------------------------------
  // Shared datapath types
  // ----------------------------------------

  // One stored word
  typedef logic [`FLOP_RAM_FIFO_WIDTH-1:0] dataWord_t;

  // RAM entry index
  // Depth is a power of two so the address wraps on its own
  typedef logic [$clog2(`FLOP_RAM_FIFO_DEPTH)-1:0] ramAddr_t;

  // Occupancy or free count
  // Needs one extra code so that a full Depth fits
  typedef logic [$clog2(`FLOP_RAM_FIFO_DEPTH + 1)-1:0] slotCount_t;

endpackage

// File: src/fifoPushCtrl.sv
`timescale 1ns/1ns

module fifoPushCtrl #(
  parameter int WriteLatency = 1
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inValid,
  input  flopRamFifoPkg::dataWord_t inData,
  output logic                      inReady,
  input  logic                      popRelease,
  output logic                      ramWrValid,
  output flopRamFifoPkg::ramAddr_t  ramWrAddr,
  output flopRamFifoPkg::dataWord_t ramWrData,
  output logic                      pushCommit
);

  // Capacity follows from the address width
  localparam int Depth = 2 ** $bits(flopRamFifoPkg::ramAddr_t);

  logic                       push;
  logic                       readyQ;
  flopRamFifoPkg::slotCount_t freeCount;
  flopRamFifoPkg::slotCount_t freeNext;
  flopRamFifoPkg::ramAddr_t   wrPtr;
  logic [WriteLatency-1:0]    commitPipe;

  // ----------------------------------------
  // Slot accounting
  // ----------------------------------------

  assign push = inValid && readyQ;

  always_comb begin
    freeNext = freeCount;
    if (push) begin
      freeNext = freeNext - flopRamFifoPkg::slotCount_t'(1);
    end
    // A slot comes back only when the output side hands a word on
    if (popRelease) begin
      freeNext = freeNext + flopRamFifoPkg::slotCount_t'(1);
    end
  end

  // Ready is a flop, so it sits low through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      freeCount <= flopRamFifoPkg::slotCount_t'(Depth);
      readyQ    <= 1'b0;
      wrPtr     <= '0;
    end else begin
      freeCount <= freeNext;
      readyQ    <= (freeNext != '0);
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
    end
  end

  assign inReady = readyQ;

  // ----------------------------------------
  // RAM write port and commit delay
  // ----------------------------------------

  assign ramWrValid = push;
  assign ramWrAddr  = wrPtr;
  assign ramWrData  = inData;

  // Word is readable WriteLatency cycles after the write
  always_ff @(posedge clk) begin
    if (rst) begin
      commitPipe <= '0;
    end else begin
      commitPipe <= WriteLatency'({commitPipe, push});
    end
  end

  assign pushCommit = commitPipe[WriteLatency-1];

endmodule

// File: src/ramFlops1r1w.sv
`timescale 1ns/1ns

module ramFlops1r1w #(
  parameter int Depth        = 8,
  parameter int BitWidth     = 16,
  parameter int WriteLatency = 1,
  parameter int ReadLatency  = 0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wrValid,
  input  flopRamFifoPkg::ramAddr_t  wrAddr,
  input  flopRamFifoPkg::dataWord_t wrData,
  input  logic                      rdAddrValid,
  input  flopRamFifoPkg::ramAddr_t  rdAddr,
  output logic                      rdDataValid,
  output flopRamFifoPkg::dataWord_t rdData
);

  logic [BitWidth-1:0]      mem [Depth];

  // Write request as seen by the array
  logic                     memWrValid;
  flopRamFifoPkg::ramAddr_t memWrAddr;
  logic [BitWidth-1:0]      memWrData;

  // ----------------------------------------
  // Write pipeline
  // ----------------------------------------

  // The array flop itself is the last write stage
  if (WriteLatency > 1) begin : gWrPipe
    logic                     validQ [WriteLatency-1];
    flopRamFifoPkg::ramAddr_t addrQ  [WriteLatency-1];
    logic [BitWidth-1:0]      dataQ  [WriteLatency-1];

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < WriteLatency - 1; i++) begin
          validQ[i] <= 1'b0;
        end
      end else begin
        validQ[0] <= wrValid;
        for (int i = 1; i < WriteLatency - 1; i++) begin
          validQ[i] <= validQ[i-1];
        end
      end
    end

    // Payload stages carry no reset
    always_ff @(posedge clk) begin
      addrQ[0] <= wrAddr;
      dataQ[0] <= wrData;
      for (int i = 1; i < WriteLatency - 1; i++) begin
        addrQ[i] <= addrQ[i-1];
        dataQ[i] <= dataQ[i-1];
      end
    end

    assign memWrValid = validQ[WriteLatency-2];
    assign memWrAddr  = addrQ[WriteLatency-2];
    assign memWrData  = dataQ[WriteLatency-2];
  end else begin : gWrDirect
    assign memWrValid = wrValid;
    assign memWrAddr  = wrAddr;
    assign memWrData  = wrData;
  end

  always_ff @(posedge clk) begin
    if (memWrValid) begin
      mem[memWrAddr] <= memWrData;
    end
  end

  // ----------------------------------------
  // Read pipeline
  // ----------------------------------------

  // Array is read combinationally, stages follow
  if (ReadLatency > 0) begin : gRdPipe
    logic                validQ [ReadLatency];
    logic [BitWidth-1:0] dataQ  [ReadLatency];

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < ReadLatency; i++) begin
          validQ[i] <= 1'b0;
        end
      end else begin
        validQ[0] <= rdAddrValid;
        for (int i = 1; i < ReadLatency; i++) begin
          validQ[i] <= validQ[i-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      dataQ[0] <= mem[rdAddr];
      for (int i = 1; i < ReadLatency; i++) begin
        dataQ[i] <= dataQ[i-1];
      end
    end

    assign rdDataValid = validQ[ReadLatency-1];
    assign rdData      = dataQ[ReadLatency-1];
  end else begin : gRdDirect
    assign rdDataValid = rdAddrValid;
    assign rdData      = mem[rdAddr];
  end

endmodule

// File: src/fifoPopCtrl.sv
`timescale 1ns/1ns

module fifoPopCtrl #(
  parameter int ReadLatency = 0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      pushCommit,
  output logic                      ramRdAddrValid,
  output flopRamFifoPkg::ramAddr_t  ramRdAddr,
  input  logic                      ramRdDataValid,
  input  flopRamFifoPkg::dataWord_t ramRdData,
  output logic                      outValid,
  output flopRamFifoPkg::dataWord_t outData,
  input  logic                      outReady,
  output logic                      popRelease
);

  // One slot per read that can be outstanding, plus the head
  localparam int StageDepth = ReadLatency + 1;
  localparam int PtrW       = (StageDepth > 1) ? $clog2(StageDepth) : 1;
  localparam int CntW       = $clog2(StageDepth + 1);

  flopRamFifoPkg::slotCount_t committedCount;
  flopRamFifoPkg::slotCount_t availCount;
  flopRamFifoPkg::ramAddr_t   rdPtr;
  logic [CntW-1:0]            inFlight;
  logic [CntW-1:0]            stagedCount;
  logic [CntW:0]              reserved;
  logic                       rdIssue;
  logic                       popFire;
  flopRamFifoPkg::dataWord_t  stageMem [StageDepth];
  logic [PtrW-1:0]            headPtr;
  logic [PtrW-1:0]            tailPtr;

  function automatic logic [PtrW-1:0] nextSlot(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(StageDepth - 1)) begin
      return '0;
    end else begin
      return ptr + 1'b1;
    end
  endfunction

  // ----------------------------------------
  // Read issue
  // ----------------------------------------

  // Commit arriving this cycle is usable at once
  assign availCount = committedCount + flopRamFifoPkg::slotCount_t'(pushCommit);
  assign reserved   = {1'b0, inFlight} + {1'b0, stagedCount};
  assign rdIssue    = (availCount != '0) && (reserved < (CntW + 1)'(StageDepth));

  assign ramRdAddrValid = rdIssue;
  assign ramRdAddr      = rdPtr;

  always_ff @(posedge clk) begin
    if (rst) begin
      committedCount <= '0;
      inFlight       <= '0;
      stagedCount    <= '0;
      rdPtr          <= '0;
      headPtr        <= '0;
      tailPtr        <= '0;
    end else begin
      committedCount <= availCount - flopRamFifoPkg::slotCount_t'(rdIssue);
      // With zero read latency issue and return cancel out
      inFlight       <= inFlight + CntW'(rdIssue) - CntW'(ramRdDataValid);
      stagedCount    <= stagedCount + CntW'(ramRdDataValid) - CntW'(popFire);
      if (rdIssue) begin
        rdPtr <= rdPtr + 1'b1;
      end
      if (ramRdDataValid) begin
        tailPtr <= nextSlot(tailPtr);
      end
      if (popFire) begin
        headPtr <= nextSlot(headPtr);
      end
    end
  end

  // ----------------------------------------
  // Staging buffer and output
  // ----------------------------------------

  // Room is reserved at issue, so a returning word always fits
  always_ff @(posedge clk) begin
    if (ramRdDataValid) begin
      stageMem[tailPtr] <= ramRdData;
    end
  end

  assign outValid   = (stagedCount != '0);
  assign outData    = stageMem[headPtr];
  assign popFire    = outValid && outReady;
  assign popRelease = popFire;

endmodule

// File: src/flopRamFifo.sv
`timescale 1ns/1ns

`include "flopRamFifo_settings.svh"

module flopRamFifo (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inValid,
  input  flopRamFifoPkg::dataWord_t inData,
  output logic                      inReady,
  output logic                      outValid,
  output flopRamFifoPkg::dataWord_t outData,
  input  logic                      outReady
);

  // ----------------------------------------
  // Internal links
  // ----------------------------------------

  // Write port, push side to RAM
  logic                      ramWrValid;
  flopRamFifoPkg::ramAddr_t  ramWrAddr;
  flopRamFifoPkg::dataWord_t ramWrData;

  // Read request and returning data
  logic                      ramRdAddrValid;
  flopRamFifoPkg::ramAddr_t  ramRdAddr;
  logic                      ramRdDataValid;
  flopRamFifoPkg::dataWord_t ramRdData;

  // Cross notices between the two controllers
  logic                      pushCommit;
  logic                      popRelease;

  fifoPushCtrl #(
    .WriteLatency(`FLOP_RAM_FIFO_WR_LATENCY)
  ) pushCtrl (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inData    (inData),
    .inReady   (inReady),
    .popRelease(popRelease),
    .ramWrValid(ramWrValid),
    .ramWrAddr (ramWrAddr),
    .ramWrData (ramWrData),
    .pushCommit(pushCommit)
  );

  ramFlops1r1w #(
    .Depth       (`FLOP_RAM_FIFO_DEPTH),
    .BitWidth    (`FLOP_RAM_FIFO_WIDTH),
    .WriteLatency(`FLOP_RAM_FIFO_WR_LATENCY),
    .ReadLatency (`FLOP_RAM_FIFO_RD_LATENCY)
  ) ram (
    .clk        (clk),
    .rst        (rst),
    .wrValid    (ramWrValid),
    .wrAddr     (ramWrAddr),
    .wrData     (ramWrData),
    .rdAddrValid(ramRdAddrValid),
    .rdAddr     (ramRdAddr),
    .rdDataValid(ramRdDataValid),
    .rdData     (ramRdData)
  );

  fifoPopCtrl #(
    .ReadLatency(`FLOP_RAM_FIFO_RD_LATENCY)
  ) popCtrl (
    .clk           (clk),
    .rst           (rst),
    .pushCommit    (pushCommit),
    .ramRdAddrValid(ramRdAddrValid),
    .ramRdAddr     (ramRdAddr),
    .ramRdDataValid(ramRdDataValid),
    .ramRdData     (ramRdData),
    .outValid      (outValid),
    .outData       (outData),
    .outReady      (outReady),
    .popRelease    (popRelease)
  );

endmodule

// File: dv/flopRamFifo_asserts.sv
`timescale 1ns/1ns

`include "flopRamFifo_settings.svh"

module flopRamFifoAsserts #(
  parameter int ReadLatency = `FLOP_RAM_FIFO_RD_LATENCY,
  parameter bit RamSide     = 1'b0
) (
  input logic                       clk,
  input logic                       rst,
  input logic                       rdReq,
  input logic                       rdRsp,
  input logic                       stallValid,
  input flopRamFifoPkg::dataWord_t  stallData,
  input logic                       stallReady,
  input logic                       issue,
  input logic                       commit
);

  if (RamSide) begin : gRam

    // ----------------------------------------
    // RAM read timing
    // ----------------------------------------

    // Data-valid trails address-valid by exactly ReadLatency cycles
    if (ReadLatency > 0) begin : gRdLat
      readLatencyExact: assert property (@(posedge clk) disable iff (rst)
        rdRsp == $past(rdReq, ReadLatency))
        else $error("RAM data-valid does not follow address-valid by %0d cycles",
                    ReadLatency);
    end else begin : gRdComb
      readLatencyZero: assert property (@(posedge clk) disable iff (rst) rdRsp == rdReq)
        else $error("RAM data-valid differs from address-valid with zero latency");
    end

  end else begin : gPop

    // ----------------------------------------
    // Output port and read issue
    // ----------------------------------------

    // Running totals of words made readable and reads sent to the RAM
    int commitTotal;
    int issueTotal;

    always_ff @(posedge clk) begin
      if (rst) begin
        commitTotal <= 0;
        issueTotal  <= 0;
      end else begin
        commitTotal <= commitTotal + int'(commit);
        issueTotal  <= issueTotal + int'(issue);
      end
    end

    // A stalled word stays put until taken
    outputHeld: assert property (@(posedge clk) disable iff (rst)
      stallValid && !stallReady |=> stallValid && $stable(stallData))
      else $error("Output word changed or dropped while stalled");

    // A read needs a word committed earlier or in the same cycle
    issueNeedsWord: assert property (@(posedge clk) disable iff (rst)
      issue |-> issueTotal < commitTotal + int'(commit))
      else $error("RAM read issued with no committed word");

  end

endmodule

// Latency check sits on the RAM, the rest on the pop side
bind ramFlops1r1w flopRamFifoAsserts #(.ReadLatency(ReadLatency), .RamSide(1'b1)) ramChecks (
  .clk(clk), .rst(rst), .rdReq(rdAddrValid), .rdRsp(rdDataValid),
  .stallValid(1'b0), .stallData('0), .stallReady(1'b1), .issue(1'b0), .commit(1'b0)
);

bind fifoPopCtrl flopRamFifoAsserts #(.RamSide(1'b0)) popChecks (
  .clk(clk), .rst(rst), .rdReq(1'b0), .rdRsp(1'b0),
  .stallValid(outValid), .stallData(outData), .stallReady(outReady),
  .issue(ramRdAddrValid), .commit(pushCommit)
);

// File: dv/flopRamFifoTb.sv
`timescale 1ns/1ns

`include "flopRamFifo_settings.svh"

module flopRamFifoTb;

  localparam int ClkPeriod        = 8;
  localparam int ResetCycles      = 8;
  localparam int Depth            = `FLOP_RAM_FIFO_DEPTH;
  // Push edge to first output cycle, empty FIFO and ready sink
  localparam int ExpLatency       = `FLOP_RAM_FIFO_WR_LATENCY + `FLOP_RAM_FIFO_RD_LATENCY + 1;
  localparam int StreamWords      = 40;
  localparam int RandomWords      = 300;
  localparam int PlannedTransfers = 1 + StreamWords + Depth + RandomWords;
  localparam int TimeoutCycles    = ResetCycles + PlannedTransfers * 20;
  localparam int ReadyPatLen      = 4096;

  logic                      clk;
  logic                      rst;
  logic                      inValid;
  flopRamFifoPkg::dataWord_t inData;
  logic                      inReady;
  logic                      outValid;
  flopRamFifoPkg::dataWord_t outData;
  logic                      outReady;

  integer                    seed;
  int                        errorCount;
  int                        passCount;
  int                        failCount;
  int                        acceptedCount;
  int                        deliveredCount;
  flopRamFifoPkg::dataWord_t expQ [$];
  flopRamFifoPkg::dataWord_t expWord;
  logic                      readyPat [ReadyPatLen];
  int                        gapLen [RandomWords];

  flopRamFifo UUT (
    .clk     (clk),
    .rst     (rst),
    .inValid (inValid),
    .inData  (inData),
    .inReady (inReady),
    .outValid(outValid),
    .outData (outData),
    .outReady(outReady)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ----------------------------------------
  // Reference model and checking
  // ----------------------------------------

  // Oldest accepted word leaves first
  function automatic flopRamFifoPkg::dataWord_t refNextWord();
    return expQ.pop_front();
  endfunction

  function automatic flopRamFifoPkg::dataWord_t randomWord();
    return flopRamFifoPkg::dataWord_t'($random(seed));
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
    $display("ERR %s=%0h expected=%0h at %0t", name, actual, expected, $time);
    errorCount++;
  endtask

  // Record each accepted input word
  always @(posedge clk) begin
    if (!rst && inValid && inReady) begin
      expQ.push_back(inData);
      acceptedCount++;
    end
  end

  // Compare each output transfer against the model
  always @(posedge clk) begin
    if (!rst && outValid && outReady) begin
      if (expQ.size() == 0) begin
        $display("Output transfer at %0t with no accepted word pending", $time);
        errorCount++;
      end else begin
        expWord = refNextWord();
        if (outData !== expWord) begin
          reportMismatch("outData", outData, expWord);
        end
      end
      deliveredCount++;
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  // Starts and ends on a falling edge, holds the word until taken
  task automatic sendWord(input flopRamFifoPkg::dataWord_t data);
    inValid = 1'b1;
    inData  = data;
    @(posedge clk);
    while (!inReady) begin
      @(posedge clk);
    end
    @(negedge clk);
    inValid = 1'b0;
  endtask

  // Extra cycles after the last word let a stray output show up
  task automatic waitDrained();
    while (deliveredCount < acceptedCount) begin
      @(negedge clk);
    end
    repeat (ExpLatency + 1) @(negedge clk);
  endtask

  task automatic finishTest(input int num, input string name, input int errsBefore);
    if (errorCount == errsBefore) begin
      $display("Test %0d %s: ok", num, name);
      passCount++;
    end else begin
      $display("Test %0d %s: failed with %0d errors", num, name, errorCount - errsBefore);
      failCount++;
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    int errsBefore;
    int startAcc;
    int startDel;
    int cycles;
    int idx;

    seed           = 68953;
    clk            = 1'b0;
    rst            = 1'b1;
    inValid        = 1'b0;
    inData         = '0;
    outReady       = 1'b0;
    errorCount     = 0;
    passCount      = 0;
    failCount      = 0;
    acceptedCount  = 0;
    deliveredCount = 0;

    // Reset: nothing offered or accepted while rst is high
    errsBefore = errorCount;
    repeat (ResetCycles) begin
      @(negedge clk);
      if (outValid !== 1'b0) reportMismatch("outValid", outValid, 1'b0);
      if (inReady !== 1'b0) reportMismatch("inReady", inReady, 1'b0);
    end
    rst = 1'b0;
    @(negedge clk);
    if (inReady !== 1'b1) reportMismatch("inReady", inReady, 1'b1);
    if (outValid !== 1'b0) reportMismatch("outValid", outValid, 1'b0);
    finishTest(1, "reset", errsBefore);

    // Single word latency, then an ordered stream
    errsBefore = errorCount;
    outReady   = 1'b1;
    startDel   = deliveredCount;
    sendWord(randomWord());
    cycles = 1;
    while (!outValid && cycles < 4 * ExpLatency) begin
      @(negedge clk);
      cycles++;
    end
    if (!outValid) begin
      $display("First word never reached the output");
      errorCount++;
    end else if (cycles != ExpLatency) begin
      reportMismatch("latencyCycles", cycles, ExpLatency);
    end
    for (int i = 0; i < StreamWords; i++) begin
      sendWord(randomWord());
    end
    waitDrained();
    if (deliveredCount - startDel != StreamWords + 1) begin
      reportMismatch("deliveredCount", deliveredCount - startDel, StreamWords + 1);
    end
    finishTest(2, "latency and order", errsBefore);

    // Fill with the output stalled
    errsBefore = errorCount;
    outReady   = 1'b0;
    startAcc   = acceptedCount;
    for (int i = 0; i < Depth; i++) begin
      if (inReady !== 1'b1) begin
        $display("inReady fell after %0d words, before the FIFO was full", i);
        errorCount++;
      end
      sendWord(randomWord());
    end
    if (inReady !== 1'b0) reportMismatch("inReady", inReady, 1'b0);
    // one extra word offered, then withdrawn untaken
    inValid = 1'b1;
    inData  = randomWord();
    repeat (2 * Depth) @(negedge clk);
    inValid = 1'b0;
    if (acceptedCount - startAcc != Depth) begin
      reportMismatch("acceptedCount", acceptedCount - startAcc, Depth);
    end
    if (inReady !== 1'b0) reportMismatch("inReady", inReady, 1'b0);
    if (outValid !== 1'b1) reportMismatch("outValid", outValid, 1'b1);
    finishTest(3, "capacity", errsBefore);

    // Drain the full FIFO
    errsBefore = errorCount;
    startDel   = deliveredCount;
    outReady   = 1'b1;
    waitDrained();
    if (deliveredCount - startDel != Depth) begin
      reportMismatch("deliveredCount", deliveredCount - startDel, Depth);
    end
    if (outValid !== 1'b0) reportMismatch("outValid", outValid, 1'b0);
    if (inReady !== 1'b1) reportMismatch("inReady", inReady, 1'b1);
    finishTest(4, "drain", errsBefore);

    // Random traffic, patterns drawn up front from the one seed
    errsBefore = errorCount;
    for (int i = 0; i < ReadyPatLen; i++) begin
      readyPat[i] = $random(seed) & 1;
    end
    for (int i = 0; i < RandomWords; i++) begin
      gapLen[i] = (($random(seed) & 3) == 0) ? ($random(seed) & 3) + 1 : 0;
    end
    startAcc = acceptedCount;
    startDel = deliveredCount;
    idx      = 0;
    fork
      begin
        for (int i = 0; i < RandomWords; i++) begin
          repeat (gapLen[i]) @(negedge clk);
          sendWord(randomWord());
        end
      end
      begin
        while (deliveredCount - startDel < RandomWords) begin
          outReady = readyPat[idx % ReadyPatLen];
          idx++;
          @(negedge clk);
        end
      end
    join
    outReady = 1'b1;
    waitDrained();
    if (deliveredCount - startDel != acceptedCount - startAcc) begin
      reportMismatch("deliveredCount", deliveredCount - startDel, acceptedCount - startAcc);
    end
    if (expQ.size() != 0) begin
      $display("%0d accepted words never came out", expQ.size());
      errorCount++;
    end
    finishTest(5, "random traffic", errsBefore);

    $display("Tests ok: %0d, tests failed: %0d, errors: %0d", passCount, failCount, errorCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Bound by the planned transfer count
  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", TimeoutCycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: flopRamFifo.f
+incdir+src
src/flopRamFifoPkg.sv
src/fifoPushCtrl.sv
src/ramFlops1r1w.sv
src/fifoPopCtrl.sv
src/flopRamFifo.sv
dv/flopRamFifo_asserts.sv
dv/flopRamFifoTb.sv

// File: run.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module flopRamFifoTb \
  -f flopRamFifo.f \
  -Mdir obj_dir

./obj_dir/VflopRamFifoTb | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
